//--- src/cluster_consts.svh
//////////////////////////////
// sizes and timing shared by RTL and testbench
// NCORES must stay a power of two
//////////////////////////////
`ifndef CLUSTER_CONSTS_SVH
`define CLUSTER_CONSTS_SVH

// word and word-address widths
`define DATA_W 32
`define ADDR_W 8

`define NCORES 2

// cycles a core keeps the bus before a switch is considered
`define ARB_SLICE_CYCLES 6

// busy cycles per memory access
`define DRAM_LATENCY 3
`define DRAM_DEPTH 256

`define OPS_PER_CORE 16
`define SHARED_ADDR 8'h00

`endif

//--- src/cluster_pkg.sv
//////////////////////////////
// types shared by the cluster blocks
//////////////////////////////
`default_nettype none

`include "cluster_consts.svh"

package cluster_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] paddr_t;

    // index of the core that owns the bus
    typedef logic [$clog2(`NCORES)-1:0] grant_t;

    // ID and HALT are the only states where a core holds no access
    typedef enum logic [2:0] {
        ID,
        RD,
        RDW,
        WR,
        WRW,
        HALT
    } cpustate_t;

    typedef enum logic [1:0] {
        RUN,
        SWITCH,
        SETTLE
    } arb_state_t;

endpackage

`default_nettype wire

//--- src/bus_arbiter.sv
//////////////////////////////
// two cores only; grant moves at operation boundaries
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "cluster_consts.svh"

module bus_arbiter import cluster_pkg::*; (
    input  logic      CLK,
    input  logic      RST_X,
    input  logic      start,
    output grant_t    grant,
    input  cpustate_t cpustate0,
    input  cpustate_t cpustate1,
    input  paddr_t    mem_addr0,
    input  paddr_t    mem_addr1,
    input  word_t     mem_wdata0,
    input  word_t     mem_wdata1,
    input  logic      mem_le0,
    input  logic      mem_le1,
    input  logic      mem_we0,
    input  logic      mem_we1,
    output word_t     mem_rdata0,
    output word_t     mem_rdata1,
    output logic      mem_busy0,
    output logic      mem_busy1,
    output paddr_t    dram_addr,
    output word_t     dram_wdata,
    output logic      dram_le,
    output logic      dram_we,
    input  word_t     dram_rdata,
    input  logic      dram_busy
);

    localparam int CNT_W = $clog2(`ARB_SLICE_CYCLES + 1);

    arb_state_t       state;
    logic [CNT_W-1:0] count;
    logic             slice_done;
    cpustate_t        cpustate_g;
    logic             at_boundary;
    logic             hold;
    logic             busy_g;

    assign slice_done  = (count == CNT_W'(`ARB_SLICE_CYCLES));
    assign cpustate_g  = (grant == grant_t'(0)) ? cpustate0 : cpustate1;
    assign at_boundary = (cpustate_g == ID) || (cpustate_g == HALT);

    // once the slice is used up, stop the granted core at its next boundary;
    // an access already in flight still sees the real busy so it can finish
    assign hold   = (state != RUN) || (slice_done && at_boundary);
    assign busy_g = dram_busy || hold;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state <= RUN;
            grant <= '0;
            count <= '0;
        end else if (start) begin
            state <= RUN;
            grant <= '0;
            count <= '0;
        end else begin
            case (state)
                RUN: begin
                    if (!slice_done) begin
                        count <= count + 1'b1;
                    end else if (at_boundary) begin
                        state <= SWITCH;
                    end
                end
                SWITCH: begin
                    // wraps since NCORES is a power of two
                    grant <= grant + grant_t'(1);
                    state <= SETTLE;
                end
                SETTLE: begin
                    // new owner still sees busy for this one cycle
                    count <= '0;
                    state <= RUN;
                end
                default: begin
                    state <= RUN;
                end
            endcase
        end
    end

    // request mux toward memory
    always_comb begin
        if (grant == grant_t'(0)) begin
            dram_addr  = mem_addr0;
            dram_wdata = mem_wdata0;
            dram_le    = mem_le0;
            dram_we    = mem_we0;
        end else begin
            dram_addr  = mem_addr1;
            dram_wdata = mem_wdata1;
            dram_le    = mem_le1;
            dram_we    = mem_we1;
        end
    end

    // response demux, the waiting core always sees busy
    always_comb begin
        if (grant == grant_t'(0)) begin
            mem_rdata0 = dram_rdata;
            mem_busy0  = busy_g;
            mem_rdata1 = '0;
            mem_busy1  = 1'b1;
        end else begin
            mem_rdata1 = dram_rdata;
            mem_busy1  = busy_g;
            mem_rdata0 = '0;
            mem_busy0  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/rmw_core.sv
//////////////////////////////
// start is taken only in HALT
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "cluster_consts.svh"

module rmw_core import cluster_pkg::*; #(
    parameter paddr_t BASE_ADDR = 8'h10,
    parameter word_t  INCREMENT = 32'd1
) (
    input  logic      CLK,
    input  logic      RST_X,
    input  logic      start,
    output cpustate_t cpustate,
    output paddr_t    mem_addr,
    output word_t     mem_wdata,
    output logic      mem_le,
    output logic      mem_we,
    input  word_t     mem_rdata,
    input  logic      mem_busy,
    output logic      done
);

    localparam int OP_W = $clog2(`OPS_PER_CORE + 1);

    cpustate_t       state;
    logic [OP_W-1:0] op_idx;
    logic            last_op;
    paddr_t          target;

    assign cpustate = state;
    assign last_op  = (op_idx == OP_W'(`OPS_PER_CORE - 1));

    // even operations hit the shared word, odd ones walk the private region
    assign target = op_idx[0] ? BASE_ADDR + paddr_t'(op_idx >> 1) : `SHARED_ADDR;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state  <= HALT;
            op_idx <= '0;
            mem_le <= 1'b0;
            mem_we <= 1'b0;
            done   <= 1'b0;
        end else begin
            case (state)
                HALT: begin
                    if (start) begin
                        op_idx <= '0;
                        done   <= 1'b0;
                        state  <= ID;
                    end
                end
                ID: begin
                    if (!mem_busy) begin
                        mem_le <= 1'b1;
                        state  <= RD;
                    end
                end
                RD: begin
                    // read pulse lasts one cycle
                    mem_le <= 1'b0;
                    state  <= RDW;
                end
                RDW: begin
                    // rdata is valid in the cycle busy drops
                    if (!mem_busy) begin
                        mem_we <= 1'b1;
                        state  <= WR;
                    end
                end
                WR: begin
                    mem_we <= 1'b0;
                    state  <= WRW;
                end
                WRW: begin
                    if (!mem_busy) begin
                        if (last_op) begin
                            done  <= 1'b1;
                            state <= HALT;
                        end else begin
                            op_idx <= op_idx + 1'b1;
                            state  <= ID;
                        end
                    end
                end
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

    // address and write data held from issue to completion
    always_ff @(posedge CLK) begin
        if (state == ID && !mem_busy) begin
            mem_addr <= target;
        end
        if (state == RDW && !mem_busy) begin
            mem_wdata <= mem_rdata + INCREMENT;
        end
    end

endmodule

`default_nettype wire

//--- src/shared_dram.sv
//////////////////////////////
// host port only while the bus is idle
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "cluster_consts.svh"

module shared_dram import cluster_pkg::*; (
    input  logic   CLK,
    input  logic   RST_X,
    input  logic   le,
    input  logic   we,
    input  paddr_t addr,
    input  word_t  wdata,
    output word_t  rdata,
    output logic   busy,
    input  logic   host_we,
    input  paddr_t host_addr,
    input  word_t  host_wdata,
    output word_t  host_rdata
);

    localparam int LAT_W = $clog2(`DRAM_LATENCY + 1);

    word_t            mem [`DRAM_DEPTH];
    logic [LAT_W-1:0] lat_cnt;
    logic             wr_q;
    paddr_t           addr_q;
    word_t            wdata_q;
    logic             accept;
    logic             finish;

    assign busy       = (lat_cnt != '0);
    assign accept     = !busy && (le || we);
    // last busy cycle, result lands as busy falls
    assign finish     = (lat_cnt == LAT_W'(1));
    assign host_rdata = mem[host_addr];

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            lat_cnt <= '0;
            wr_q    <= 1'b0;
        end else if (busy) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else if (accept) begin
            lat_cnt <= LAT_W'(`DRAM_LATENCY);
            wr_q    <= we;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (finish && !wr_q) begin
            rdata <= mem[addr_q];
        end
    end

    always_ff @(posedge CLK) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end else if (finish && wr_q) begin
            mem[addr_q] <= wdata_q;
        end
    end

endmodule

`default_nettype wire

//--- src/cluster_top.sv
//////////////////////////////
// two cores on one shared memory
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cluster_top import cluster_pkg::*; (
    input  logic   CLK,
    input  logic   RST_X,
    input  logic   start,
    input  logic   host_we,
    input  paddr_t host_addr,
    input  word_t  host_wdata,
    output word_t  host_rdata,
    output grant_t grant,
    output logic   done0,
    output logic   done1
);

    cpustate_t cpustate0, cpustate1;
    paddr_t    mem_addr0, mem_addr1;
    word_t     mem_wdata0, mem_wdata1;
    word_t     mem_rdata0, mem_rdata1;
    logic      mem_le0, mem_le1;
    logic      mem_we0, mem_we1;
    logic      mem_busy0, mem_busy1;
    paddr_t    dram_addr;
    word_t     dram_wdata, dram_rdata;
    logic      dram_le, dram_we, dram_busy;

    rmw_core #(.BASE_ADDR(8'h10), .INCREMENT(32'd1)) u_core0 (
        .CLK(CLK), .RST_X(RST_X), .start(start), .cpustate(cpustate0),
        .mem_addr(mem_addr0), .mem_wdata(mem_wdata0), .mem_le(mem_le0),
        .mem_we(mem_we0), .mem_rdata(mem_rdata0), .mem_busy(mem_busy0), .done(done0)
    );

    rmw_core #(.BASE_ADDR(8'h20), .INCREMENT(32'd3)) u_core1 (
        .CLK(CLK), .RST_X(RST_X), .start(start), .cpustate(cpustate1),
        .mem_addr(mem_addr1), .mem_wdata(mem_wdata1), .mem_le(mem_le1),
        .mem_we(mem_we1), .mem_rdata(mem_rdata1), .mem_busy(mem_busy1), .done(done1)
    );

    bus_arbiter u_arbiter (
        .CLK(CLK), .RST_X(RST_X), .start(start), .grant(grant),
        .cpustate0(cpustate0), .cpustate1(cpustate1),
        .mem_addr0(mem_addr0), .mem_addr1(mem_addr1),
        .mem_wdata0(mem_wdata0), .mem_wdata1(mem_wdata1),
        .mem_le0(mem_le0), .mem_le1(mem_le1), .mem_we0(mem_we0), .mem_we1(mem_we1),
        .mem_rdata0(mem_rdata0), .mem_rdata1(mem_rdata1),
        .mem_busy0(mem_busy0), .mem_busy1(mem_busy1),
        .dram_addr(dram_addr), .dram_wdata(dram_wdata), .dram_le(dram_le),
        .dram_we(dram_we), .dram_rdata(dram_rdata), .dram_busy(dram_busy)
    );

    shared_dram u_dram (
        .CLK(CLK), .RST_X(RST_X), .le(dram_le), .we(dram_we),
        .addr(dram_addr), .wdata(dram_wdata), .rdata(dram_rdata), .busy(dram_busy),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

endmodule

`default_nettype wire

//--- verification/cluster_properties.sv
//////////////////////////////
// bound into bus_arbiter, two cores only
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cluster_properties import cluster_pkg::*; (
    input logic       CLK,
    input logic       RST_X,
    input logic       start,
    input arb_state_t state,
    input grant_t     grant,
    input logic       mem_busy0,
    input logic       mem_busy1,
    input logic       mem_le0,
    input logic       mem_le1,
    input logic       mem_we0,
    input logic       mem_we1,
    input logic       dram_le,
    input logic       dram_we
);

    int fail_count = 0;

    // outside of start, grant only moves out of SWITCH
    a_switch_settle: assert property (@(posedge CLK) disable iff (!RST_X)
        (!$past(start) && grant != $past(grant)) |-> state == SETTLE)
        else begin
            $error("grant changed without a following SETTLE");
            fail_count++;
        end

    a_idle_busy: assert property (@(posedge CLK) disable iff (!RST_X)
        (grant == grant_t'(0)) ? mem_busy1 : mem_busy0)
        else begin
            $error("core without the grant sees busy low");
            fail_count++;
        end

    a_idle_quiet: assert property (@(posedge CLK) disable iff (!RST_X)
        (grant == grant_t'(0)) ? !(mem_le1 || mem_we1) : !(mem_le0 || mem_we0))
        else begin
            $error("core without the grant drives a read or write strobe");
            fail_count++;
        end

    // core strobes are single-cycle pulses
    a_strobe_pulse: assert property (@(posedge CLK) disable iff (!RST_X)
        (dram_le || dram_we) |=> !(dram_le || dram_we))
        else begin
            $error("memory strobe held longer than one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verification/cluster_checker.sv
//////////////////////////////
// test 0 checks reset values and tests 4 and 8 arbitration
// the other tests compare host reads with the reference
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cluster_checker import cluster_pkg::*; (
    input  logic       CLK,
    input  logic       RST_X,
    input  logic       start,
    input  grant_t     grant,
    input  logic       done0,
    input  logic       done1,
    input  paddr_t     host_addr,
    input  word_t      host_rdata,
    input  logic       cmp_en,
    input  word_t      exp_word,
    input  logic [3:0] test_sel,
    input  logic       test_end,
    output int         error_count,
    output int         check_count,
    output int         test_count
);

    string names [9] = '{"reset_state", "run1_shared", "run1_private", "run1_untouched",
        "run1_arbitration", "run2_shared", "run2_private", "run2_untouched", "run2_arbitration"};

    int     test_errs;
    int     test_checks;
    int     switch_count;
    int     restart_errs;
    logic   start_q;
    grant_t grant_q;

    task automatic count_check(logic ok);
        test_checks++;
        check_count++;
        if (!ok) begin
            test_errs++;
            error_count++;
        end
    endtask

    task automatic check_value(string what, word_t expected, word_t actual);
        count_check(actual === expected);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
                     names[test_sel], what, expected, actual);
        end
    endtask

    task automatic check_true(logic ok, string problem);
        count_check(ok);
        if (!ok) begin
            $display("%s: %s", names[test_sel], problem);
        end
    endtask

    task automatic finish_test();
        if (test_sel == 4'd0) begin
            check_value("grant", '0, word_t'(grant));
            check_value("done0", '0, word_t'(done0));
            check_value("done1", '0, word_t'(done1));
        end
        if (test_sel == 4'd4 || test_sel == 4'd8) begin
            check_true(switch_count > 0, "grant never changed while both cores were running");
            check_true(done0 && done1, "done0 and done1 are not both high after the run");
            check_true(restart_errs == 0, "a done level stayed high after start");
            restart_errs = 0;
        end
        $display("test %s %s: %0d checks, %0d errors", names[test_sel],
                 (test_errs == 0) ? "passed" : "failed", test_checks, test_errs);
        test_count++;
        test_errs   = 0;
        test_checks = 0;
    endtask

    always @(posedge CLK) begin
        if (!RST_X) begin
            error_count  = 0;
            check_count  = 0;
            test_count   = 0;
            test_errs    = 0;
            test_checks  = 0;
            switch_count = 0;
            restart_errs = 0;
            start_q      = 1'b0;
            grant_q      = '0;
        end else begin
            if (cmp_en) begin
                check_value($sformatf("addr 0x%02h", host_addr), exp_word, host_rdata);
            end
            // done clears on the edge that takes start
            if (start_q) begin
                if (done0 || done1) begin
                    restart_errs++;
                end
            end else if (!done0 && !done1 && grant != grant_q) begin
                switch_count++;
            end
            if (start) begin
                switch_count = 0;
            end
            if (test_end) begin
                finish_test();
            end
            start_q = start;
            grant_q = grant;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_cluster.sv
//////////////////////////////
// preloads words 0x00..0x2f, then runs two starts without a new preload
// host port is used only while both cores sit in HALT
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "cluster_consts.svh"

module tb_cluster import cluster_pkg::*; ();

    localparam int          HALF_PERIOD   = 10;
    localparam int          RESET_CYCLES  = 3;
    localparam int          PRELOAD_WORDS = 48;
    localparam int          PRIV_WORDS    = `OPS_PER_CORE / 2;
    localparam paddr_t      BASE0         = 8'h10;
    localparam paddr_t      BASE1         = 8'h20;
    localparam word_t       INC0          = 32'd1;
    localparam word_t       INC1          = 32'd3;
    localparam logic [31:0] SEED          = 32'hd63c;
    localparam int          TIMEOUT_RUNS  = 3;
    // worst case per operation, including a grant change
    localparam int OP_CYCLES      = 2 * `DRAM_LATENCY + 4 + `ARB_SLICE_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = TIMEOUT_RUNS * 2 * `NCORES * `OPS_PER_CORE * OP_CYCLES;

    localparam int REGION_SHARED  = 0;
    localparam int REGION_PRIVATE = 1;
    localparam int REGION_OTHER   = 2;

    logic   CLK;
    logic   RST_X;
    logic   start;
    logic   host_we;
    paddr_t host_addr;
    word_t  host_wdata;
    word_t  host_rdata;
    grant_t grant;
    logic   done0;
    logic   done1;
    logic       cmp_en;
    word_t      exp_word;
    logic [3:0] test_sel;
    logic       test_end;
    int         error_count;
    int         check_count;
    int         test_count;
    word_t      preload [PRELOAD_WORDS];

    cluster_top dut (
        .CLK(CLK), .RST_X(RST_X), .start(start), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .grant(grant),
        .done0(done0), .done1(done1)
    );

    cluster_checker u_checker (
        .CLK(CLK), .RST_X(RST_X), .start(start), .grant(grant), .done0(done0), .done1(done1),
        .host_addr(host_addr), .host_rdata(host_rdata), .cmp_en(cmp_en), .exp_word(exp_word),
        .test_sel(test_sel), .test_end(test_end), .error_count(error_count),
        .check_count(check_count), .test_count(test_count)
    );

    bind bus_arbiter cluster_properties u_props (
        .CLK(CLK), .RST_X(RST_X), .start(start), .state(state), .grant(grant),
        .mem_busy0(mem_busy0), .mem_busy1(mem_busy1), .mem_le0(mem_le0), .mem_le1(mem_le1),
        .mem_we0(mem_we0), .mem_we1(mem_we1), .dram_le(dram_le), .dram_we(dram_we)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #HALF_PERIOD CLK = ~CLK;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("watchdog: cores did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    function automatic int region_of(paddr_t a);
        if (a == `SHARED_ADDR) begin
            return REGION_SHARED;
        end
        if ((a >= BASE0 && a < BASE0 + PRIV_WORDS) ||
            (a >= BASE1 && a < BASE1 + PRIV_WORDS)) begin
            return REGION_PRIVATE;
        end
        return REGION_OTHER;
    endfunction

    // shared word takes both increments once per even operation,
    // each private word takes its core's increment once per run
    function automatic word_t expected_word(paddr_t a, word_t pre, int runs);
        word_t delta;
        case (region_of(a))
            REGION_SHARED:  delta = word_t'(`OPS_PER_CORE / 2) * (INC0 + INC1);
            REGION_PRIVATE: delta = (a < BASE1) ? INC0 : INC1;
            default:        delta = '0;
        endcase
        return pre + word_t'(runs) * delta;
    endfunction

    task automatic preload_memory();
        for (int a = 0; a < PRELOAD_WORDS; a++) begin
            @(negedge CLK);
            preload[a] = $urandom();
            host_we    = 1'b1;
            host_addr  = paddr_t'(a);
            host_wdata = preload[a];
        end
        @(negedge CLK);
        host_we = 1'b0;
    endtask

    task automatic run_cluster();
        @(negedge CLK);
        start = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        while (!(done0 && done1)) begin
            @(negedge CLK);
        end
    endtask

    task automatic close_test(input logic [3:0] sel);
        @(negedge CLK);
        test_sel = sel;
        test_end = 1'b1;
        @(negedge CLK);
        test_end = 1'b0;
    endtask

    task automatic compare_region(input logic [3:0] sel, input int region, input int runs);
        @(negedge CLK);
        test_sel = sel;
        for (int a = 0; a < PRELOAD_WORDS; a++) begin
            if (region_of(paddr_t'(a)) == region) begin
                host_addr = paddr_t'(a);
                exp_word  = expected_word(paddr_t'(a), preload[a], runs);
                cmp_en    = 1'b1;
                @(negedge CLK);
            end
        end
        cmp_en   = 1'b0;
        test_end = 1'b1;
        @(negedge CLK);
        test_end = 1'b0;
    endtask

    initial begin
        int assert_fails;
        RST_X      = 1'b0;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        cmp_en     = 1'b0;
        exp_word   = '0;
        test_sel   = '0;
        test_end   = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST_X = 1'b1;
        close_test(4'd0);
        preload_memory();
        run_cluster();
        compare_region(4'd1, REGION_SHARED, 1);
        compare_region(4'd2, REGION_PRIVATE, 1);
        compare_region(4'd3, REGION_OTHER, 1);
        close_test(4'd4);
        run_cluster();
        compare_region(4'd5, REGION_SHARED, 2);
        compare_region(4'd6, REGION_PRIVATE, 2);
        compare_region(4'd7, REGION_OTHER, 2);
        close_test(4'd8);
        @(negedge CLK);
        assert_fails = dut.u_arbiter.u_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/cluster_pkg.sv
src/bus_arbiter.sv
src/rmw_core.sv
src/shared_dram.sv
src/cluster_top.sv
verification/cluster_properties.sv
verification/cluster_checker.sv
verification/tb_cluster.sv

//--- run.sh
#!/bin/sh
# builds the cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cluster -f list.f
out=$(./obj_dir/Vtb_cluster +verilator+error+limit+1000)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
    exit 0
fi
exit 1
